/* tb.f */
+incdir+.
logic/pkt_match_pkg.sv
logic/pkt_framer.sv
logic/type_matcher.sv
logic/symbol_matcher.sv
logic/result_fifo.sv
logic/pkt_match_top.sv
tests/tb_pkt_match.sv

/* Bender.yml */
package:
  name: pkt_match

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - logic/pkt_match_pkg.sv
      - logic/pkt_framer.sv
      - logic/type_matcher.sv
      - logic/symbol_matcher.sv
      - logic/result_fifo.sv
      - logic/pkt_match_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tests/tb_pkt_match.sv

/* tests/tb_pkt_match.sv */
/*
 * Packet matcher testbench
 * Directed and random packets checked against a reference model
 */

`timescale 1ns/1ps

`include "pkt_match_cfg.svh"

module tb_pkt_match import pkt_match_pkg::*; ();

  // Driven cycles per test, idle cycles included
  localparam int T_PASS         = 8;
  localparam int T_BOTH         = 7;
  localparam int T_PART         = 12;
  localparam int T_TAIL         = 12;
  localparam int T_PRIO         = 14;
  localparam int RAND_PKTS      = 20;
  localparam int T_RAND         = RAND_PKTS * 6;
  localparam int STIM_CYCLES    = T_PASS + T_BOTH + T_PART + T_TAIL + T_PRIO + T_RAND;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;

  logic         clk_net = 1'b0;
  logic         rst_host;
  logic         in_vld;
  pkt_word_t    in_word;
  type_off_t    type_off;
  packet_type_t pkt_type;
  sym_table_t   sym_table;
  logic         out_vld;
  result_t      out_word;

  // Expected words and the cycle each one is due at the output
  result_t      exp_q[$];
  int           due_q[$];
  result_t      cmp_exp;
  int           cmp_due;

  // Reference state of the packet in flight
  logic         ref_in_pkt;
  word_off_t    ref_idx;
  type_off_t    ref_toff;
  packet_type_t ref_ptype;
  sym_table_t   ref_tbl;
  logic         ref_got_t;
  logic         ref_got_s;
  buffer_t      ref_buf;

  logic [63:0]  pkt_data [8];
  int           cyc = 0;
  int           errors = 0;
  int           checked = 0;
  int           err_mark = 0;
  int           chk_mark = 0;
  int           seed;

  always #2 clk_net = ~clk_net;

  pkt_match_top DUT (
    .clk_net   (clk_net),
    .rst_host  (rst_host),
    .in_vld    (in_vld),
    .in_word   (in_word),
    .type_off  (type_off),
    .pkt_type  (pkt_type),
    .sym_table (sym_table),
    .out_vld   (out_vld),
    .out_word  (out_word)
  );

  // Cycle count and run limit
  always @(posedge clk_net) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("ERROR: run stopped at cycle %0d, %0d expected words never arrived",
               cyc, exp_q.size());
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // Four bytes starting at byte off, zero past the word end
  function automatic packet_type_t type_at(input logic [63:0] d, input int off);
    packet_type_t p;
    for (int j = 0; j < `PM_TYPE_BYTES; j++) begin
      if (off + j < `PM_WORD_BYTES) begin
        p[j] = d[(off+j)*8 +: 8];
      end else begin
        p[j] = 8'h00;
      end
    end
    return p;
  endfunction

  // Expected host word, updates the per-packet match flags
  function automatic result_t expect_result(input pkt_word_t w, input word_off_t idx,
                                            input type_off_t toff, input packet_type_t ptype,
                                            input sym_table_t tbl, inout logic got_t,
                                            inout logic got_s, inout buffer_t buf_v);
    result_t r;
    logic    type_hit;
    logic    full;
    int      b;
    type_hit = (idx == toff.word) && (int'(toff.off) <= `PM_TYPE_MAX_OFF);
    for (int j = 0; j < `PM_TYPE_BYTES; j++) begin
      b = int'(toff.off) + j;
      // Bytes past the word or past the tail length never match
      if (b >= `PM_WORD_BYTES) begin
        type_hit = 1'b0;
      end else if (w.eop && b > int'(w.length)) begin
        type_hit = 1'b0;
      end else if (w.data[b] != ptype[j]) begin
        type_hit = 1'b0;
      end
    end
    if (type_hit) begin
      got_t = 1'b1;
    end
    full = !w.eop || (w.length == 3'd7);
    // Later entries override earlier ones
    for (int i = 0; i < `PM_NUM_SYMBOLS; i++) begin
      if (full && tbl[i].valid && tbl[i].off == idx && w.data == tbl[i].match) begin
        got_s = 1'b1;
        buf_v = tbl[i].buffer;
      end
    end
    r.sop    = w.sop;
    r.eop    = w.eop;
    r.length = w.length;
    r.data   = w.data;
    r.buffer = (w.eop && got_t && got_s) ? buf_v : '0;
    return r;
  endfunction

  // Track framing of a driven word and queue its expected result
  task automatic model_word(input pkt_word_t w);
    result_t e;
    if (w.sop || ref_in_pkt) begin
      if (w.sop) begin
        ref_toff  = type_off;
        ref_ptype = pkt_type;
        ref_tbl   = sym_table;
        ref_idx   = '0;
        ref_got_t = 1'b0;
        ref_got_s = 1'b0;
        ref_buf   = '0;
      end
      e = expect_result(w, ref_idx, ref_toff, ref_ptype, ref_tbl, ref_got_t, ref_got_s, ref_buf);
      exp_q.push_back(e);
      // Sampled next edge, then FIFO write and output register
      due_q.push_back(cyc + 3);
      ref_idx    = ref_idx + 1'b1;
      ref_in_pkt = !w.eop;
    end
  endtask

  task automatic drive_word(input pkt_word_t w);
    in_vld  = 1'b1;
    in_word = w;
    model_word(w);
    @(posedge clk_net);
    #1;
  endtask

  task automatic drive_idle();
    in_vld  = 1'b0;
    in_word = '0;
    @(posedge clk_net);
    #1;
  endtask

  function automatic pkt_word_t make_word(input int i, input int n, input logic [2:0] last_len);
    pkt_word_t w;
    int        r;
    r        = $random(seed);
    w.sop    = (i == 0);
    w.eop    = (i == n - 1);
    w.length = w.eop ? last_len : r[2:0];
    w.data   = pkt_data[i];
    return w;
  endfunction

  task automatic send_packet(input int n, input logic [2:0] last_len);
    for (int i = 0; i < n; i++) begin
      drive_word(make_word(i, n, last_len));
    end
    drive_idle();
  endtask

  task automatic fill_data();
    for (int i = 0; i < 8; i++) begin
      pkt_data[i] = rand64();
    end
  endtask

  // Operands that match nothing
  task automatic clear_ops();
    type_off  = '{word: 8'hff, off: 3'd0};
    pkt_type  = '0;
    sym_table = '0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_net);
    end
    #1;
  endtask

  task automatic end_test(input string name);
    wait_drain();
    $display("test %-18s %0d words checked, %0d errors", name,
             checked - chk_mark, errors - err_mark);
    chk_mark = checked;
    err_mark = errors;
  endtask

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else begin
        $display("MISMATCH %s: got %h expected %h", name, got, exp);
        errors++;
      end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_net) begin
    if (!rst_host) begin
      if (out_vld) begin
        assert (exp_q.size() != 0)
          else begin
            $display("ERROR: output word at cycle %0d with no word expected", cyc);
            errors++;
          end
        if (exp_q.size() != 0) begin
          cmp_exp = exp_q.pop_front();
          cmp_due = due_q.pop_front();
          checked++;
          assert (cmp_due == cyc)
            else begin
              $display("ERROR: output word at cycle %0d was due at cycle %0d", cyc, cmp_due);
              errors++;
            end
          check_field("out_word.sop", 64'(out_word.sop), 64'(cmp_exp.sop));
          check_field("out_word.eop", 64'(out_word.eop), 64'(cmp_exp.eop));
          check_field("out_word.length", 64'(out_word.length), 64'(cmp_exp.length));
          check_field("out_word.data", out_word.data, cmp_exp.data);
          check_field("out_word.buffer", 64'(out_word.buffer), 64'(cmp_exp.buffer));
        end
      end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
        assert (out_vld)
          else begin
            $display("ERROR: no output word at cycle %0d where one was due", cyc);
            errors++;
          end
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  initial begin
    int r;
    int n;
    int rs;
    seed       = 56;
    rst_host   = 1'b1;
    in_vld     = 1'b0;
    in_word    = '0;
    ref_in_pkt = 1'b0;
    clear_ops();
    repeat (8) @(posedge clk_net);
    #1;
    rst_host = 1'b0;

    // Stray words outside a packet are dropped
    fill_data();
    drive_word(make_word(2, 3, 3'd7));
    send_packet(3, 3'd2);
    drive_word(make_word(1, 3, 3'd0));
    send_packet(1, 3'd5);
    end_test("pass_through");

    // Type and symbol both hit, multi-word then single-word packet
    fill_data();
    clear_ops();
    type_off     = '{word: 8'd1, off: 3'd2};
    pkt_type     = type_at(pkt_data[1], 2);
    sym_table[2] = '{1'b1, 8'd2, pkt_data[2], 16'hbeef};
    send_packet(4, 3'd7);
    fill_data();
    clear_ops();
    type_off     = '{word: 8'd0, off: 3'd4};
    pkt_type     = type_at(pkt_data[0], 4);
    sym_table[0] = '{1'b1, 8'd0, pkt_data[0], 16'h1234};
    send_packet(1, 3'd7);
    end_test("both_match");

    // Type only
    fill_data();
    clear_ops();
    type_off = '{word: 8'd0, off: 3'd0};
    pkt_type = type_at(pkt_data[0], 0);
    send_packet(3, 3'd7);
    // Symbol only
    fill_data();
    clear_ops();
    type_off     = '{word: 8'd1, off: 3'd1};
    pkt_type     = ~type_at(pkt_data[1], 1);
    sym_table[1] = '{1'b1, 8'd2, pkt_data[2], 16'h0bad};
    send_packet(3, 3'd7);
    // Offset 5 is out of range even with matching bytes
    fill_data();
    clear_ops();
    type_off     = '{word: 8'd1, off: 3'd5};
    pkt_type     = type_at(pkt_data[1], 5);
    sym_table[1] = '{1'b1, 8'd2, pkt_data[2], 16'h0bad};
    send_packet(3, 3'd7);
    end_test("partial_match");

    // Symbol in a short tail word
    fill_data();
    clear_ops();
    type_off     = '{word: 8'd0, off: 3'd0};
    pkt_type     = type_at(pkt_data[0], 0);
    sym_table[3] = '{1'b1, 8'd2, pkt_data[2], 16'hc0de};
    send_packet(3, 3'd5);
    // Type window runs past the tail length
    fill_data();
    clear_ops();
    type_off     = '{word: 8'd2, off: 3'd3};
    pkt_type     = type_at(pkt_data[2], 3);
    sym_table[0] = '{1'b1, 8'd1, pkt_data[1], 16'h7777};
    send_packet(3, 3'd5);
    // Window inside the tail still matches
    fill_data();
    clear_ops();
    type_off     = '{word: 8'd2, off: 3'd1};
    pkt_type     = type_at(pkt_data[2], 1);
    sym_table[0] = '{1'b1, 8'd0, pkt_data[0], 16'h4242};
    send_packet(3, 3'd4);
    end_test("partial_tail");

    // Two entries hit the same word
    fill_data();
    clear_ops();
    type_off     = '{word: 8'd0, off: 3'd2};
    pkt_type     = type_at(pkt_data[0], 2);
    sym_table[1] = '{1'b1, 8'd1, pkt_data[1], 16'h1111};
    sym_table[3] = '{1'b1, 8'd1, pkt_data[1], 16'h3333};
    send_packet(3, 3'd7);
    // Operands change after sop and only apply from the next packet
    fill_data();
    clear_ops();
    type_off     = '{word: 8'd2, off: 3'd0};
    pkt_type     = type_at(pkt_data[2], 0);
    sym_table[0] = '{1'b1, 8'd3, pkt_data[3], 16'h5a5a};
    drive_word(make_word(0, 4, 3'd7));
    clear_ops();
    for (int i = 1; i < 4; i++) begin
      drive_word(make_word(i, 4, 3'd7));
    end
    drive_idle();
    send_packet(4, 3'd7);
    end_test("priority_capture");

    // Random packets with operands that often point into the payload
    for (int p = 0; p < RAND_PKTS; p++) begin
      fill_data();
      clear_ops();
      r             = $random(seed);
      n             = 1 + r[9:8];
      type_off.word = {6'd0, r[1:0]};
      type_off.off  = r[4:2];
      if (r[5]) begin
        pkt_type = type_at(pkt_data[r[1:0]], r[4:2]);
      end else begin
        pkt_type = $random(seed);
      end
      for (int s = 0; s < `PM_NUM_SYMBOLS; s++) begin
        rs                  = $random(seed);
        sym_table[s].valid  = rs[0];
        sym_table[s].off    = {6'd0, rs[5:4]};
        sym_table[s].match  = rs[6] ? pkt_data[rs[5:4]] : rand64();
        sym_table[s].buffer = rs[31:16];
      end
      if (r[11:10] == 2'b00) begin
        drive_word(make_word(1, 3, 3'd0));
      end
      send_packet(n, r[14:12]);
    end
    end_test("random");

    $display("summary: %0d words checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* logic/pkt_match_top.sv */
/*
 * Packet matcher top level
 * Framer with type and symbol matchers feeding the result FIFO
 */

`timescale 1ns/1ps

module pkt_match_top import pkt_match_pkg::*; (
  input  logic         clk_net,
  input  logic         rst_host,
  input  logic         in_vld,
  input  pkt_word_t    in_word,
  input  type_off_t    type_off,
  input  packet_type_t pkt_type,
  input  sym_table_t   sym_table,
  output logic         out_vld,
  output result_t      out_word
);

  // Framer to matchers
  logic         cur_vld;
  pkt_word_t    cur_word;
  word_off_t    word_off;
  type_off_t    type_off_q;
  packet_type_t pkt_type_q;
  sym_table_t   sym_table_q;

  // Matcher verdicts
  logic         type_found;
  match_res_t   sym_res;

  // Framer to FIFO
  logic         push;
  result_t      push_data;

  pkt_framer u_framer (
    .clk_net     (clk_net),
    .rst_host    (rst_host),
    .in_vld      (in_vld),
    .in_word     (in_word),
    .type_off    (type_off),
    .pkt_type    (pkt_type),
    .sym_table   (sym_table),
    .type_found  (type_found),
    .sym_res     (sym_res),
    .cur_vld     (cur_vld),
    .cur_word    (cur_word),
    .word_off    (word_off),
    .type_off_q  (type_off_q),
    .pkt_type_q  (pkt_type_q),
    .sym_table_q (sym_table_q),
    .push        (push),
    .push_data   (push_data)
  );

  type_matcher u_type_matcher (
    .cur_vld    (cur_vld),
    .cur_word   (cur_word),
    .word_off   (word_off),
    .type_off_q (type_off_q),
    .pkt_type_q (pkt_type_q),
    .type_found (type_found)
  );

  symbol_matcher u_symbol_matcher (
    .cur_vld     (cur_vld),
    .cur_word    (cur_word),
    .word_off    (word_off),
    .sym_table_q (sym_table_q),
    .sym_res     (sym_res)
  );

  // Results carry the full host word
  result_fifo #(
    .T_DATA (result_t)
  ) u_result_fifo (
    .clk_net   (clk_net),
    .rst_host  (rst_host),
    .push      (push),
    .push_data (push_data),
    .out_vld   (out_vld),
    .out_data  (out_word)
  );

endmodule

/* logic/result_fifo.sv */
/*
 * Result FIFO
 * Synchronous circular buffer that drains itself into a registered output
 */

`timescale 1ns/1ps

`include "pkt_match_cfg.svh"

module result_fifo import pkt_match_pkg::*; #(
  parameter type T_DATA = result_t,
  parameter int  DEPTH  = `PM_FIFO_DEPTH
) (
  input  logic  clk_net,
  input  logic  rst_host,
  input  logic  push,
  input  T_DATA push_data,
  output logic  out_vld,
  output T_DATA out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T_DATA            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             empty;
  logic             full;
  logic             pop;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // No host back-pressure so drain every cycle there is data
  assign pop = ~empty;

  always_ff @(posedge clk_net) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at DEPTH for any depth
  always_ff @(posedge clk_net) begin
    if (rst_host) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_net) begin
    if (rst_host) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    end
  end

  // Occupancy holds when push and pop coincide
  always_ff @(posedge clk_net) begin
    if (rst_host) begin
      count <= '0;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end

  // Output stage
  always_ff @(posedge clk_net) begin
    if (rst_host) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= pop;
    end
  end

  always_ff @(posedge clk_net) begin
    if (pop) begin
      out_data <= mem[rd_ptr];
    end
  end

  no_push_full: assert property (@(posedge clk_net) disable iff (rst_host)
    !(push && full))
    else $error("push into a full result FIFO");

  count_bound: assert property (@(posedge clk_net) disable iff (rst_host)
    count <= CNT_W'(DEPTH))
    else $error("result FIFO occupancy above depth");

endmodule

/* logic/symbol_matcher.sv */
/*
 * Symbol matcher
 * Compares the current word against each symbol entry at its word index
 */

`timescale 1ns/1ps

`include "pkt_match_cfg.svh"

module symbol_matcher import pkt_match_pkg::*; (
  input  logic       cur_vld,
  input  pkt_word_t  cur_word,
  input  word_off_t  word_off,
  input  sym_table_t sym_table_q,
  output match_res_t sym_res
);

  logic [`PM_NUM_SYMBOLS-1:0] hit;
  logic                       full_word;
  buffer_t                    sel_buffer;

  // Symbols are a whole word so a short tail cannot hold one
  assign full_word = ~cur_word.eop | (cur_word.length == '1);

  always_comb begin
    for (int i = 0; i < `PM_NUM_SYMBOLS; i++) begin
      hit[i] = sym_table_q[i].valid
             & (sym_table_q[i].off == word_off)
             & (cur_word.data == sym_table_q[i].match);
    end
  end

  // Ascending scan so the highest index wins
  always_comb begin
    sel_buffer = '0;
    for (int i = 0; i < `PM_NUM_SYMBOLS; i++) begin
      if (hit[i]) begin
        sel_buffer = sym_table_q[i].buffer;
      end
    end
  end

  assign sym_res.found  = cur_vld & full_word & (|hit);
  assign sym_res.buffer = sel_buffer;

  // Overlapping entries point to a bad table
  multi_hit: assert final (!(cur_vld && full_word) || $onehot0(hit))
    else $warning("several symbol entries hit the same word");

endmodule

/* logic/type_matcher.sv */
/*
 * Type field matcher
 * Compares the 4 type bytes against every legal window of the current word
 */

`timescale 1ns/1ps

`include "pkt_match_cfg.svh"

module type_matcher import pkt_match_pkg::*; (
  input  logic         cur_vld,
  input  pkt_word_t    cur_word,
  input  word_off_t    word_off,
  input  type_off_t    type_off_q,
  input  packet_type_t pkt_type_q,
  output logic         type_found
);

  byte_mask_t valid_mask;
  byte_mask_t win_hit;
  logic       in_word;
  logic       off_ok;

  // All bytes count unless this is a short tail word
  assign valid_mask = len_to_mask(cur_word.length) | {`PM_WORD_BYTES{~cur_word.eop}};

  // Expected word and a start offset that keeps the field inside it
  assign in_word = (word_off == type_off_q.word);
  assign off_ok  = (int'(type_off_q.off) <= `PM_TYPE_MAX_OFF);

  always_comb begin
    win_hit = '0;
    for (int i = 0; i <= `PM_TYPE_MAX_OFF; i++) begin
      win_hit[i] = 1'b1;
      for (int j = 0; j < `PM_TYPE_BYTES; j++) begin
        // An invalid byte anywhere in the window kills it
        win_hit[i] &= valid_mask[i+j] & (cur_word.data[i+j] == pkt_type_q[j]);
      end
    end
  end

  assign type_found = cur_vld & in_word & off_ok & win_hit[type_off_q.off];

endmodule

/* logic/pkt_framer.sv */
/*
 * Packet framer
 * Latches ingress words, tracks packet boundaries and word index,
 * holds match state per packet and builds the result pushed to the FIFO
 */

`timescale 1ns/1ps

module pkt_framer import pkt_match_pkg::*; (
  input  logic         clk_net,
  input  logic         rst_host,
  input  logic         in_vld,
  input  pkt_word_t    in_word,
  input  type_off_t    type_off,
  input  packet_type_t pkt_type,
  input  sym_table_t   sym_table,
  input  logic         type_found,
  input  match_res_t   sym_res,
  output logic         cur_vld,
  output pkt_word_t    cur_word,
  output word_off_t    word_off,
  output type_off_t    type_off_q,
  output packet_type_t pkt_type_q,
  output sym_table_t   sym_table_q,
  output logic         push,
  output result_t      push_data
);

  typedef enum logic {
    IDLE      = 1'b0,
    IN_PACKET = 1'b1
  } state_t;

  // Match progress kept across the words of one packet
  typedef struct packed {
    logic    got_type;
    logic    got_symbol;
    buffer_t buffer;
  } match_st_t;

  state_t    state_q;
  state_t    state_d;
  logic      capture;
  match_st_t match_q;
  match_st_t match_d;

  // Operands load with the sop word itself
  assign capture = in_vld & in_word.sop;

  always_comb begin
    state_d = state_q;
    push    = 1'b0;
    case (state_q)
      IDLE: begin
        // Resync on sop, stray body words are dropped
        if (cur_vld && cur_word.sop) begin
          push = 1'b1;
          if (!cur_word.eop) begin
            state_d = IN_PACKET;
          end
        end
      end
      IN_PACKET: begin
        if (cur_vld) begin
          push = 1'b1;
          // Tail word closes the packet
          if (cur_word.eop) begin
            state_d = IDLE;
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Fold the current word's hits into the retained state
  always_comb begin
    match_d            = match_q;
    match_d.got_type   = match_q.got_type | (push & type_found);
    match_d.got_symbol = match_q.got_symbol | (push & sym_res.found);
    if (push && sym_res.found) begin
      match_d.buffer = sym_res.buffer;
    end
  end

  // Payload forwarded unchanged
  always_comb begin
    push_data.sop    = cur_word.sop;
    push_data.eop    = cur_word.eop;
    push_data.length = cur_word.length;
    push_data.data   = cur_word.data;
    // Tag only on eop and only with both hits in this packet
    if (cur_word.eop && match_d.got_type && match_d.got_symbol) begin
      push_data.buffer = match_d.buffer;
    end else begin
      push_data.buffer = '0;
    end
  end

  always_ff @(posedge clk_net) begin
    if (rst_host) begin
      cur_vld <= 1'b0;
    end else begin
      cur_vld <= in_vld;
    end
  end

  always_ff @(posedge clk_net) begin
    if (in_vld) begin
      cur_word <= in_word;
    end
  end

  always_ff @(posedge clk_net) begin
    if (capture) begin
      type_off_q  <= type_off;
      pkt_type_q  <= pkt_type;
      sym_table_q <= sym_table;
    end
  end

  always_ff @(posedge clk_net) begin
    if (rst_host) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word index restarts at zero for the incoming sop
  always_ff @(posedge clk_net) begin
    if (rst_host || capture) begin
      word_off <= '0;
    end else if (push) begin
      word_off <= word_off + 1'b1;
    end
  end

  always_ff @(posedge clk_net) begin
    if (rst_host || capture) begin
      match_q <= '0;
    end else if (push) begin
      match_q <= match_d;
    end
  end

  // A new packet opens only after the previous one closed
  sop_when_idle: assert property (@(posedge clk_net) disable iff (rst_host)
    (cur_vld && cur_word.sop) |-> (state_q == IDLE))
    else $error("framer got sop inside an open packet");

endmodule

/* logic/pkt_match_pkg.sv */
/*
 * Packet matcher types
 * Ingress word, match operands, symbol table and result formats
 */

`include "pkt_match_cfg.svh"

package pkt_match_pkg;

  localparam int LEN_BITS = $clog2(`PM_WORD_BYTES);

  // Word index inside a packet
  typedef logic [`PM_WORD_OFF_BITS-1:0] word_off_t;

  // Host buffer tag
  typedef logic [`PM_BUFFER_BITS-1:0] buffer_t;

  // One bit per byte of a word
  typedef logic [`PM_WORD_BYTES-1:0] byte_mask_t;

  // Ingress word, length is the last valid byte on eop
  typedef struct packed {
    logic                            sop;
    logic                            eop;
    logic [LEN_BITS-1:0]             length;
    logic [`PM_WORD_BYTES-1:0][7:0]  data;
  } pkt_word_t;

  // Location of the type field
  typedef struct packed {
    word_off_t           word;
    logic [LEN_BITS-1:0] off;
  } type_off_t;

  // Type field bytes, byte 0 first on the wire
  typedef logic [`PM_TYPE_BYTES-1:0][7:0] packet_type_t;

  // One symbol entry
  typedef struct packed {
    logic                             valid;
    word_off_t                        off;
    logic [`PM_WORD_BYTES*8-1:0]      match;
    buffer_t                          buffer;
  } sym_entry_t;

  typedef sym_entry_t [`PM_NUM_SYMBOLS-1:0] sym_table_t;

  // Symbol matcher verdict for the current word
  typedef struct packed {
    logic    found;
    buffer_t buffer;
  } match_res_t;

  // Host side word
  typedef struct packed {
    logic                            sop;
    logic                            eop;
    logic [LEN_BITS-1:0]             length;
    logic [`PM_WORD_BYTES-1:0][7:0]  data;
    buffer_t                         buffer;
  } result_t;

  // Bytes 0 up to len are valid
  function automatic byte_mask_t len_to_mask(input logic [LEN_BITS-1:0] len);
    byte_mask_t mask;
    for (int i = 0; i < `PM_WORD_BYTES; i++) begin
      mask[i] = (i <= int'(len));
    end
    return mask;
  endfunction

endpackage

/* pkt_match_cfg.svh */
/*
 * Packet matcher configuration
 * Word geometry, symbol table size and result FIFO depth
 */

`ifndef PKT_MATCH_CFG_SVH
`define PKT_MATCH_CFG_SVH

// Bytes carried by one ingress word
`define PM_WORD_BYTES 8

// Type field size and its highest legal start byte
`define PM_TYPE_BYTES 4
`define PM_TYPE_MAX_OFF 4

// Symbol table entries
`define PM_NUM_SYMBOLS 4

// Word index and buffer tag widths
`define PM_WORD_OFF_BITS 8
`define PM_BUFFER_BITS 16

// Result FIFO entries
`define PM_FIFO_DEPTH 16

`endif
